//--- Bender.yml
package:
  name: dcache

sources:
  - source/dCachePkg.sv
  - source/tagStore.sv
  - source/dataStore.sv
  - source/missController.sv
  - source/dCacheTop.sv
  - target: test
    files:
      - dv/lineMemModel.sv
      - dv/dCacheTb.sv

//--- dCacheTop.f
source/dCachePkg.sv
source/tagStore.sv
source/dataStore.sv
source/missController.sv
source/dCacheTop.sv
dv/lineMemModel.sv
dv/dCacheTb.sv

//--- dv/dCacheTb.sv
`timescale 1ns/1ps

module dCacheTb;
	localparam int memDelay = 3;
	localparam int resetCycles = 16;
	localparam int missLen = 2 * (memDelay + 3) + 6; // write-back, refill, re-compare
	localparam int numAccesses = 32;
	localparam int timeoutCycles = resetCycles + 2 * numAccesses * missLen + 800;

	logic clk;
	logic reset;
	logic reqValid;
	logic reqWrite;
	dCachePkg::cacheAddrU reqAddr;
	dCachePkg::wordT reqWdata;
	logic reqReady;
	logic respValid;
	dCachePkg::wordT respData;
	logic memReqValid;
	logic memReqWrite;
	dCachePkg::cacheAddrU memReqAddr;
	dCachePkg::lineT memWline;
	logic memAck;
	dCachePkg::lineT memRline;
	int memReads;
	int memWrites;
	int readsAtWrite;
	logic [31:0] lastReadAddr;
	logic [31:0] lastWriteAddr;
	dCachePkg::lineT lastWriteLine;

	dCachePkg::wordT respQ [$];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	integer seed = 32'hc24b_6008;

	dCacheTop u_dCacheTop (.*);

	lineMemModel #(.delay(memDelay)) memModel (
		.clk(clk),
		.memReqValid(memReqValid),
		.memReqWrite(memReqWrite),
		.memReqAddr(memReqAddr),
		.memWline(memWline),
		.memAck(memAck),
		.memRline(memRline),
		.reads(memReads),
		.writes(memWrites),
		.readsAtWrite(readsAtWrite),
		.lastReadAddr(lastReadAddr),
		.lastWriteAddr(lastWriteAddr),
		.lastWriteLine(lastWriteLine)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		while (cycles < timeoutCycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped after %0d cycles, the cache never finished", cycles);
		$display("Checks failed");
		$finish;
	end

	always @(negedge clk) begin
		if (respValid)
			respQ.push_back(respData);
	end

	task automatic checkEq(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error: %s expected %0h got %0h", name, expected, actual);
		end
	endtask

	function automatic logic [31:0] addrOf(input logic [23:0] tag, input logic [3:0] index,
			input logic [1:0] word);
		return {tag, index, word, 2'b00};
	endfunction

	// initial memory word, a function of its byte address
	function automatic dCachePkg::wordT expectedWord(input logic [31:0] addr);
		logic [31:0] wordAddr;
		wordAddr = {addr[31:2], 2'b00};
		return (wordAddr * 32'h0001_0003) ^ 32'h5a5a_a5a5;
	endfunction

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic sendReq(input logic write, input logic [31:0] addr,
			input dCachePkg::wordT data);
		reqValid = 1'b1;
		reqWrite = write;
		reqAddr.raw = addr;
		reqWdata = data;
		while (!reqReady)
			@(negedge clk);
		@(negedge clk);
		reqValid = 1'b0;
	endtask

	task automatic waitResp(input int count);
		while (respQ.size() < count)
			@(negedge clk);
	endtask

	task automatic readCheck(input logic [31:0] addr, input dCachePkg::wordT expected);
		sendReq(1'b0, addr, '0);
		waitResp(1);
		checkEq("respData", expected, respQ.pop_front());
	endtask

	task automatic storeWord(input logic [31:0] addr, input dCachePkg::wordT data);
		sendReq(1'b1, addr, data);
		waitResp(1);
		void'(respQ.pop_front()); // write response carries no data
	endtask

	task automatic checkIdleAfterReset();
		repeat (4) begin
			checkEq("reqReady", 1, reqReady);
			checkEq("respValid", 0, respValid);
			checkEq("memReqValid", 0, memReqValid);
			@(negedge clk);
		end
	endtask

	task automatic readMissThenHit();
		logic [31:0] addr;
		int traffic;
		addr = addrOf(24'h000012, 4'd1, 2'd2);
		traffic = memReads + memWrites;
		readCheck(addr, expectedWord(addr));
		checkEq("memory requests", traffic + 1, memReads + memWrites);
		checkEq("refill address", addr & ~32'hf, lastReadAddr);
		readCheck(addr, expectedWord(addr));
		checkEq("memory requests", traffic + 1, memReads + memWrites); // hit
	endtask

	task automatic writeHitsBackToBack();
		logic [31:0] base;
		dCachePkg::wordT w0;
		dCachePkg::wordT w2;
		int traffic;
		base = addrOf(24'h000034, 4'd2, 2'd0);
		w0 = $random(seed);
		w2 = $random(seed);
		readCheck(base + 4, expectedWord(base + 4)); // line now resident
		traffic = memReads + memWrites;
		storeWord(base, w0);
		readCheck(base, w0);
		sendReq(1'b1, base + 8, w2);
		sendReq(1'b0, base + 8, '0);
		sendReq(1'b0, base, '0);
		sendReq(1'b0, base + 12, '0);
		sendReq(1'b0, base + 4, '0);
		waitResp(5);
		void'(respQ.pop_front());
		checkEq("respData", w2, respQ.pop_front());
		checkEq("respData", w0, respQ.pop_front());
		checkEq("respData", expectedWord(base + 12), respQ.pop_front());
		checkEq("respData", expectedWord(base + 4), respQ.pop_front());
		repeat (4) @(negedge clk);
		checkEq("extra responses", 0, respQ.size());
		checkEq("memory requests", traffic, memReads + memWrites);
	endtask

	task automatic lruReplacement();
		logic [31:0] lineA;
		logic [31:0] lineB;
		logic [31:0] lineC;
		int traffic;
		lineA = addrOf(24'h0000a1, 4'd3, 2'd1);
		lineB = addrOf(24'h0000b2, 4'd3, 2'd1);
		lineC = addrOf(24'h0000c3, 4'd3, 2'd1);
		readCheck(lineA, expectedWord(lineA));
		readCheck(lineB, expectedWord(lineB));
		readCheck(lineA, expectedWord(lineA)); // B is now least recent
		readCheck(lineC, expectedWord(lineC));
		checkEq("refill address", lineC & ~32'hf, lastReadAddr);
		traffic = memReads + memWrites;
		readCheck(lineA, expectedWord(lineA));
		checkEq("memory requests", traffic, memReads + memWrites);
		readCheck(lineB, expectedWord(lineB));
		checkEq("memory requests", traffic + 1, memReads + memWrites);
		checkEq("refill address", lineB & ~32'hf, lastReadAddr);
	endtask

	task automatic writeBackOnEviction();
		logic [31:0] lineA;
		logic [31:0] lineB;
		logic [31:0] lineC;
		dCachePkg::wordT data;
		dCachePkg::lineT expLine;
		int readsBefore;
		int writesBefore;
		lineA = addrOf(24'h0001a0, 4'd4, 2'd3);
		lineB = addrOf(24'h0001b0, 4'd4, 2'd0);
		lineC = addrOf(24'h0001c0, 4'd4, 2'd0);
		data = $random(seed);
		storeWord(lineA, data); // allocates A and leaves it dirty
		readCheck(lineB, expectedWord(lineB));
		readsBefore = memReads;
		writesBefore = memWrites;
		readCheck(lineC, expectedWord(lineC));
		for (int i = 0; i < 3; i++)
			expLine[i*32 +: 32] = expectedWord((lineA & ~32'hf) + 32'(4 * i));
		expLine[127:96] = data;
		checkEq("write-back count", writesBefore + 1, memWrites);
		checkEq("write-back address", lineA & ~32'hf, lastWriteAddr);
		checkEq("memWline", expLine, lastWriteLine);
		checkEq("refills before write-back", readsBefore, readsAtWrite);
		checkEq("refill count", readsBefore + 1, memReads);
		checkEq("refill address", lineC & ~32'hf, lastReadAddr);
		readCheck(lineA, data);
		checkEq("refill count", readsBefore + 2, memReads);
		checkEq("refill address", lineA & ~32'hf, lastReadAddr);
	endtask

	initial begin
		reset = 1'b1;
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqAddr = '0;
		reqWdata = '0;
		repeat (resetCycles) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		checkIdleAfterReset();
		readMissThenHit();
		writeHitsBackToBack();
		lruReplacement();
		writeBackOnEviction();
		repeat (4) @(negedge clk);
		checkEq("pending responses", 0, respQ.size());
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- dv/lineMemModel.sv
`timescale 1ns/1ps

module lineMemModel #(
	parameter int delay = 3
) (
	input logic clk,
	input logic memReqValid,
	input logic memReqWrite,
	input dCachePkg::cacheAddrU memReqAddr,
	input dCachePkg::lineT memWline,
	output logic memAck,
	output dCachePkg::lineT memRline,
	output int reads,
	output int writes,
	output int readsAtWrite,
	output logic [31:0] lastReadAddr,
	output logic [31:0] lastWriteAddr,
	output dCachePkg::lineT lastWriteLine
);
	dCachePkg::lineT written [logic [31:0]]; // lines written back so far
	int waitCnt;

	// untouched memory holds a pattern of the byte address
	function automatic dCachePkg::lineT initialLine(input logic [31:0] lineAddr);
		dCachePkg::lineT line;
		logic [31:0] wordAddr;
		for (int i = 0; i < dCachePkg::lineWords; i++) begin
			wordAddr = lineAddr + 32'(4 * i);
			line[i*32 +: 32] = (wordAddr * 32'h0001_0003) ^ 32'h5a5a_a5a5;
		end
		return line;
	endfunction

	initial begin
		memAck = 1'b0;
		memRline = '0;
		reads = 0;
		writes = 0;
		readsAtWrite = 0;
		lastReadAddr = '0;
		lastWriteAddr = '0;
		lastWriteLine = '0;
		waitCnt = 0;
	end

	always @(negedge clk) begin
		if (memAck) begin
			memAck <= 1'b0; // request drops after the ack
		end else if (memReqValid) begin
			if (waitCnt < delay - 1) begin
				waitCnt <= waitCnt + 1;
			end else begin
				waitCnt <= 0;
				memAck <= 1'b1;
				if (memReqWrite) begin
					written[memReqAddr.raw] = memWline;
					writes <= writes + 1;
					readsAtWrite <= reads;
					lastWriteAddr <= memReqAddr.raw;
					lastWriteLine <= memWline;
				end else begin
					memRline <= written.exists(memReqAddr.raw) ? written[memReqAddr.raw]
						: initialLine(memReqAddr.raw);
					reads <= reads + 1;
					lastReadAddr <= memReqAddr.raw;
				end
			end
		end
	end

endmodule

//--- source/dCachePkg.sv
package dCachePkg;

	// fixed geometry
	localparam int addrWidth = 32;
	localparam int wordWidth = 32;
	localparam int lineWords = 4;
	localparam int offsetWidth = 4; // byte within a line
	localparam int indexWidth = 4;
	localparam int tagWidth = 24;
	localparam int numSets = 16;

	typedef logic [wordWidth-1:0] wordT;

	// word 0 sits in the low bits
	typedef logic [lineWords*wordWidth-1:0] lineT;

	typedef logic wayT;

	// raw view gets compared and registered, field view gets sliced
	typedef union packed {
		logic [addrWidth-1:0] raw;
		struct packed {
			logic [tagWidth-1:0] tag;
			logic [indexWidth-1:0] index;
			logic [1:0] wordSel;
			logic [1:0] byteSel;
		} f;
	} cacheAddrU;

endpackage

//--- source/dCacheTop.sv
`timescale 1ns/1ps

module dCacheTop (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input logic reqWrite,
	input dCachePkg::cacheAddrU reqAddr,
	input dCachePkg::wordT reqWdata,
	input logic memAck,
	input dCachePkg::lineT memRline,
	output logic reqReady,
	output logic respValid,
	output dCachePkg::wordT respData,
	output logic memReqValid,
	output logic memReqWrite,
	output dCachePkg::cacheAddrU memReqAddr,
	output dCachePkg::lineT memWline
);
	logic [dCachePkg::indexWidth-1:0] accessIndex;
	logic [1:0] accessWord;
	dCachePkg::wayT accessWay;
	logic writeEn;
	dCachePkg::wordT writeWord;
	logic fillEn;
	dCachePkg::lineT fillLine;
	dCachePkg::wordT readWord;
	dCachePkg::lineT victimLine;
	logic missStart;
	logic victimDirty;
	dCachePkg::cacheAddrU victimAddr;
	dCachePkg::cacheAddrU fillAddr;
	logic wbDone;
	logic fillDone;
	logic busy;

	tagStore u_tagStore (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.reqWdata(reqWdata),
		.readWord(readWord),
		.wbDone(wbDone),
		.fillDone(fillDone),
		.busy(busy),
		.reqReady(reqReady),
		.respValid(respValid),
		.respData(respData),
		.accessIndex(accessIndex),
		.accessWord(accessWord),
		.accessWay(accessWay),
		.writeEn(writeEn),
		.writeWord(writeWord),
		.fillEn(fillEn),
		.missStart(missStart),
		.victimDirty(victimDirty),
		.victimAddr(victimAddr),
		.fillAddr(fillAddr)
	);

	dataStore u_dataStore (
		.clk(clk),
		.accessIndex(accessIndex),
		.accessWord(accessWord),
		.accessWay(accessWay),
		.writeEn(writeEn),
		.writeWord(writeWord),
		.fillEn(fillEn),
		.fillLine(fillLine),
		.readWord(readWord),
		.victimLine(victimLine)
	);

	missController u_missController (
		.clk(clk),
		.reset(reset),
		.missStart(missStart),
		.victimDirty(victimDirty),
		.victimAddr(victimAddr),
		.fillAddr(fillAddr),
		.victimLine(victimLine),
		.memAck(memAck),
		.memRline(memRline),
		.busy(busy),
		.wbDone(wbDone),
		.fillDone(fillDone),
		.fillLine(fillLine),
		.memReqValid(memReqValid),
		.memReqWrite(memReqWrite),
		.memReqAddr(memReqAddr),
		.memWline(memWline)
	);

endmodule

//--- source/dataStore.sv
`timescale 1ns/1ps

module dataStore (
	input logic clk,
	input logic [dCachePkg::indexWidth-1:0] accessIndex,
	input logic [1:0] accessWord,
	input dCachePkg::wayT accessWay,
	input logic writeEn,
	input dCachePkg::wordT writeWord,
	input logic fillEn,
	input dCachePkg::lineT fillLine,
	output dCachePkg::wordT readWord,
	output dCachePkg::lineT victimLine
);
	dCachePkg::lineT lines [2][dCachePkg::numSets];

	// whole line of the accessed way, also used for write-back
	assign victimLine = lines[accessWay][accessIndex];
	assign readWord = victimLine[accessWord*dCachePkg::wordWidth +: dCachePkg::wordWidth];

	always_ff @(posedge clk) begin
		if (fillEn)
			lines[accessWay][accessIndex] <= fillLine;
		else if (writeEn)
			lines[accessWay][accessIndex][accessWord*dCachePkg::wordWidth +: dCachePkg::wordWidth]
				<= writeWord;
	end

	// refill and word write come from different pipeline states
	fillWriteExcl: assert property (@(posedge clk) writeEn |-> !fillEn);

endmodule

//--- source/missController.sv
`timescale 1ns/1ps

module missController (
	input logic clk,
	input logic reset,
	input logic missStart,
	input logic victimDirty,
	input dCachePkg::cacheAddrU victimAddr,
	input dCachePkg::cacheAddrU fillAddr,
	input dCachePkg::lineT victimLine,
	input logic memAck,
	input dCachePkg::lineT memRline,
	output logic busy,
	output logic wbDone,
	output logic fillDone,
	output dCachePkg::lineT fillLine,
	output logic memReqValid,
	output logic memReqWrite,
	output dCachePkg::cacheAddrU memReqAddr,
	output dCachePkg::lineT memWline
);
	localparam logic [1:0] idle = 2'd0;
	localparam logic [1:0] writeBack = 2'd1;
	localparam logic [1:0] refill = 2'd2;
	localparam logic [1:0] done = 2'd3;

	logic [1:0] state;
	dCachePkg::cacheAddrU victimAddrQ;
	dCachePkg::cacheAddrU fillAddrQ;
	dCachePkg::lineT lineQ; // victim line first, then the refilled line

	assign busy = state != idle;
	assign wbDone = (state == writeBack) && memAck;
	assign fillDone = state == done;
	assign fillLine = lineQ;
	assign memReqWrite = state == writeBack;
	assign memReqAddr = (state == writeBack) ? victimAddrQ : fillAddrQ;
	assign memWline = lineQ;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			memReqValid <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (missStart) begin
						state <= victimDirty ? writeBack : refill;
						memReqValid <= 1'b1;
					end
				end
				writeBack: begin
					if (memAck) begin
						memReqValid <= 1'b0; // one idle cycle between requests
						state <= refill;
					end
				end
				refill: begin
					if (memAck) begin
						memReqValid <= 1'b0;
						state <= done;
					end else begin
						memReqValid <= 1'b1;
					end
				end
				default: state <= idle; // done lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && missStart) begin
			victimAddrQ.raw <= victimAddr.raw;
			fillAddrQ.raw <= fillAddr.raw;
			lineQ <= victimLine;
		end else if (state == refill && memAck) begin
			lineQ <= memRline;
		end
	end

	// address holds until the memory takes the request
	reqAddrStable: assert property (@(posedge clk) disable iff (reset)
		(memReqValid && !memAck) |=> $stable(memReqAddr.raw));

endmodule

//--- source/tagStore.sv
`timescale 1ns/1ps

module tagStore (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input logic reqWrite,
	input dCachePkg::cacheAddrU reqAddr,
	input dCachePkg::wordT reqWdata,
	input dCachePkg::wordT readWord,
	input logic wbDone,
	input logic fillDone,
	input logic busy,
	output logic reqReady,
	output logic respValid,
	output dCachePkg::wordT respData,
	output logic [dCachePkg::indexWidth-1:0] accessIndex,
	output logic [1:0] accessWord,
	output dCachePkg::wayT accessWay,
	output logic writeEn,
	output dCachePkg::wordT writeWord,
	output logic fillEn,
	output logic missStart,
	output logic victimDirty,
	output dCachePkg::cacheAddrU victimAddr,
	output dCachePkg::cacheAddrU fillAddr
);
	logic [dCachePkg::tagWidth-1:0] tagArr [2][dCachePkg::numSets];
	logic [1:0][dCachePkg::numSets-1:0] validArr;
	logic [1:0][dCachePkg::numSets-1:0] dirtyArr;
	logic [dCachePkg::numSets-1:0] lruWay; // way to replace next

	// request stage
	logic s1Valid;
	logic s1Write;
	dCachePkg::cacheAddrU s1Addr;
	dCachePkg::wordT s1Wdata;
	// compare stage
	logic s2Valid;
	logic s2Write;
	dCachePkg::cacheAddrU s2Addr;
	dCachePkg::wordT s2Wdata;

	logic [dCachePkg::indexWidth-1:0] idx;
	logic hit0;
	logic hit1;
	logic hit;
	logic stall;
	dCachePkg::wayT victimWay;

	assign idx = s2Addr.f.index;
	assign hit0 = validArr[0][idx] && (tagArr[0][idx] == s2Addr.f.tag);
	assign hit1 = validArr[1][idx] && (tagArr[1][idx] == s2Addr.f.tag);
	assign hit = hit0 || hit1;
	assign victimWay = lruWay[idx];
	assign stall = s2Valid && !hit; // hold both stages until the refill lands

	assign reqReady = !stall;
	assign missStart = stall && !busy;
	assign accessIndex = idx;
	assign accessWord = s2Addr.f.wordSel;
	assign accessWay = hit ? dCachePkg::wayT'(hit1) : victimWay;
	assign writeEn = s2Valid && hit && s2Write;
	assign writeWord = s2Wdata;
	assign fillEn = fillDone;
	assign victimDirty = validArr[victimWay][idx] && dirtyArr[victimWay][idx];

	always_comb begin
		victimAddr.raw = '0;
		victimAddr.f.tag = tagArr[victimWay][idx];
		victimAddr.f.index = idx;
		fillAddr.raw = s2Addr.raw;
		fillAddr.f.wordSel = '0; // line aligned
		fillAddr.f.byteSel = '0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
			respValid <= 1'b0;
		end else begin
			respValid <= s2Valid && hit;
			if (!stall) begin
				s2Valid <= s1Valid;
				s1Valid <= reqValid;
			end
		end
	end

	always_ff @(posedge clk) begin
		respData <= readWord;
		if (!stall) begin
			s2Write <= s1Write;
			s2Addr <= s1Addr;
			s2Wdata <= s1Wdata;
			if (reqValid) begin
				s1Write <= reqWrite;
				s1Addr.raw <= reqAddr.raw;
				s1Wdata <= reqWdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			validArr <= '0;
			dirtyArr <= '0;
			lruWay <= '0;
		end else begin
			if (s2Valid && hit)
				lruWay[idx] <= !hit1; // other way becomes the victim
			if (writeEn)
				dirtyArr[hit1][idx] <= 1'b1;
			if (wbDone)
				dirtyArr[victimWay][idx] <= 1'b0;
			if (fillDone) begin
				validArr[victimWay][idx] <= 1'b1;
				dirtyArr[victimWay][idx] <= 1'b0;
				lruWay[idx] <= !victimWay;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fillDone)
			tagArr[victimWay][idx] <= s2Addr.f.tag;
	end

	// no response while the miss controller still runs
	missNoResp: assert property (@(posedge clk) disable iff (reset)
		busy |=> !respValid);

endmodule
